// File: project.f
+incdir+hw
hw/memPkg.sv
hw/mbusPkg.sv
hw/mb20Phase.sv
hw/wordFifo.sv
hw/mbusDriver.sv
hw/mb20.sv
dv/mb20_asserts.sv
dv/mb20Tb.sv

// File: Bender.yml
package:
  name: mb20

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/memPkg.sv
      - hw/mbusPkg.sv
      - hw/mb20Phase.sv
      - hw/wordFifo.sv
      - hw/mbusDriver.sv
      - hw/mb20.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - dv/mb20_asserts.sv
      - dv/mb20Tb.sv

// File: dv/mb20Tb.sv
/* Testbench for the MB20 model. Preloads part of the core array, runs quadword
   read cycles with and without bus hold and checks each word against a model */
`timescale 1ns/1ps
`include "mb20_defs.svh"

module mb20Tb
  import memPkg::*, mbusPkg::*;
();

  localparam int AddrBits = `MB20_ADDRBITS;
  localparam int PreloadWords = 64;                    // Region all cycles read from
  localparam int NumCycles = 47;                       // Start cycles issued in total
  localparam int TimeoutCycles = 40 * NumCycles + 200;

  // One expected bus word
  typedef struct packed {
    W36 data;
    logic par;
  } tExpWord;

  // Expected words of one cycle, in bus order
  typedef struct packed {
    logic [2:0] count;
    tExpWord [0:`MB20_QUADWORDS-1] words;
  } tExpList;

  bit clk;
  bit reset;
  bit start;
  tMbusStart startInfo;
  bit busHold;
  bit writeEn;
  tMemAddr writeAddr;
  W36 writeData;
  bit ackn;
  bit busy;
  W36 dIn;
  bit parIn;
  bit validIn;

  W36 shadow [`MB20_MEMWORDS];  // Mirror of the core array
  tExpWord expQ [$];            // Words still owed by the bus
  int seed = 32'hb77e;
  int mismatches;
  int otherErrors;
  int acknCount;
  int cycleCount;

  always #10 clk = ~clk;  // 20 ns period

  mb20 i_mb20 (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .startInfo(startInfo),
    .ackn     (ackn),
    .busHold  (busHold),
    .dIn      (dIn),
    .parIn    (parIn),
    .validIn  (validIn),
    .writeEn  (writeEn),
    .writeAddr(writeAddr),
    .writeData(writeData),
    .busy     (busy)
  );

  // Mask bit k picks offset (start offset + k) mod 4, parity is odd
  function automatic tExpList refCycle(input tMemAddr addr, input tReqMask mask);
    tExpList res;
    tExpWord ew;
    tMemAddr wAddr;
    int idx;
    res = '0;
    for (int k = 0; k < `MB20_QUADWORDS; k++) begin
      if (mask[k]) begin
        wAddr = addr;
        wAddr.quad.offset = OffBits'((int'(addr.quad.offset) + k) % `MB20_QUADWORDS);
        idx = int'(wAddr.linear) % `MB20_MEMWORDS;
        ew.data = shadow[idx];
        ew.par = ~^shadow[idx];
        res.words[res.count] = ew;
        res.count = res.count + 1'b1;
      end
    end
    return res;
  endfunction

  task automatic writeWord(input tMemAddr addr, input W36 data);
    @(posedge clk);
    writeEn <= 1'b1;
    writeAddr <= addr;
    writeData <= data;
    shadow[int'(addr.linear) % `MB20_MEMWORDS] = data;
    @(posedge clk);
    writeEn <= 1'b0;
  endtask

  // Runs the bus until the cycle is done, optionally with random hold stretches
  task automatic waitDone(input bit holdOn);
    bit done;
    int holdLeft;
    done = 1'b0;
    holdLeft = 0;
    while (!done) begin
      @(posedge clk);
      if (holdOn) begin
        if (holdLeft > 0) begin
          busHold <= 1'b1;
          holdLeft--;
        end else if ($unsigned($random(seed)) % 3 == 0) begin
          holdLeft = 1 + $unsigned($random(seed)) % 6;  // New stretch
          busHold <= 1'b1;
        end else begin
          busHold <= 1'b0;
        end
      end else begin
        busHold <= 1'b0;
      end
      @(negedge clk);
      // Under hold the next start may meet words still queued
      done = !busy && (holdOn || expQ.size() == 0);
    end
  endtask

  // One read cycle; dupStart keeps start high a second cycle, which must be ignored
  task automatic runCycle(input tMemAddr addr, input tReqMask mask, input bit holdOn,
                          input bit dupStart);
    tExpList expList;
    tMemAddr ghost;
    int acknStart;
    expList = refCycle(addr, mask);
    for (int i = 0; i < expList.count; i++) begin
      expQ.push_back(expList.words[i]);
    end
    acknStart = acknCount;
    ghost = addr;
    ghost.linear = addr.linear + 8;  // Another quadword
    @(posedge clk);
    start <= 1'b1;
    startInfo.addr <= addr;
    startInfo.reqMask <= mask;
    @(posedge clk);  // Start taken at this edge
    if (dupStart) begin
      startInfo.addr <= ghost;  // Arrives while busy
      startInfo.reqMask <= '1;
    end else begin
      start <= 1'b0;
    end
    @(negedge clk);
    assert (busy == (mask != '0)) else begin
      otherErrors++;
      $display("ERROR at %0t: busy is %b the cycle after a start with mask %b", $time,
               busy, mask);
    end
    if (dupStart) begin
      @(posedge clk);
      start <= 1'b0;
    end
    waitDone(holdOn);
    assert (acknCount - acknStart == int'(expList.count)) else begin
      otherErrors++;
      $display("ERROR at %0t: %0d ackn pulses for %0d requested words", $time,
               acknCount - acknStart, expList.count);
    end
  endtask

  always @(posedge clk) begin : countAckn
    if (!reset && ackn) acknCount++;
  end

  // Each bus word must be the next one owed
  always @(posedge clk) begin : compareWords
    tExpWord want;
    if (!reset && validIn) begin
      assert (expQ.size() != 0) else begin
        otherErrors++;
        $display("ERROR at %0t: word %h arrived with none expected", $time, dIn);
      end
      if (expQ.size() != 0) begin
        want = expQ.pop_front();
        assert (dIn == want.data) else begin
          mismatches++;
          $display("MISMATCH at %0t: data %h, expected %h", $time, dIn, want.data);
        end
        assert (parIn == want.par) else begin
          mismatches++;
          $display("MISMATCH at %0t: parity %b, expected %b", $time, parIn, want.par);
        end
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycleCount++;
    if (cycleCount > TimeoutCycles) begin
      $display("ERROR: run timed out after %0d cycles with %0d words outstanding",
               cycleCount, expQ.size());
      $display("Checks done: %0d mismatches, %0d other errors", mismatches, otherErrors);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin : mainSeq
    tMemAddr a;
    tReqMask m;
    W36 d;
    int nWrites;
    reset = 1'b1;
    start = 1'b0;
    startInfo = '0;
    busHold = 1'b0;
    writeEn = 1'b0;
    writeAddr = '0;
    writeData = '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    a = '0;
    for (int i = 0; i < PreloadWords; i++) begin
      a.linear = AddrBits'(i);
      d = W36'({$random(seed), $random(seed)});
      writeWord(a, d);
    end
    a.linear = AddrBits'(8);   // Offset 0, full quadword in order
    runCycle(a, 4'b1111, 1'b0, 1'b0);
    a.linear = AddrBits'(18);  // Offset 2 wraps 2 3 0 1
    runCycle(a, 4'b1111, 1'b0, 1'b0);
    a.linear = AddrBits'(20);  // Sparse masks
    runCycle(a, 4'b0101, 1'b0, 1'b0);
    a.linear = AddrBits'(33);
    runCycle(a, 4'b1000, 1'b0, 1'b0);
    a.linear = AddrBits'(47);
    runCycle(a, 4'b0110, 1'b0, 1'b0);
    for (int i = 0; i < 10; i++) begin
      a.linear = AddrBits'($unsigned($random(seed)) % PreloadWords);
      m = tReqMask'($random(seed));
      runCycle(a, m, 1'b1, 1'b0);
    end
    a.linear = AddrBits'(24);  // Second start while busy
    runCycle(a, 4'b1111, 1'b0, 1'b1);
    a.linear = AddrBits'(26);
    writeWord(a, 36'h5_a5a5_0f0f);
    a.linear = AddrBits'(24);  // Mask bit 2 is offset 2, the word just written
    runCycle(a, 4'b0010, 1'b0, 1'b0);
    for (int i = 0; i < 30; i++) begin
      nWrites = $unsigned($random(seed)) % 3;
      for (int w = 0; w < nWrites; w++) begin
        a.linear = AddrBits'($unsigned($random(seed)) % PreloadWords);
        d = W36'({$random(seed), $random(seed)});
        writeWord(a, d);
      end
      a.linear = AddrBits'($unsigned($random(seed)) % PreloadWords);
      m = tReqMask'($random(seed));
      runCycle(a, m, 1'($random(seed)), 1'b0);
    end
    @(posedge clk);
    busHold <= 1'b0;             // Words queued behind a hold drain now
    repeat (10) @(posedge clk);  // Room for stray words
    assert (expQ.size() == 0) else begin
      otherErrors++;
      $display("ERROR: %0d expected words never arrived", expQ.size());
    end
    otherErrors += i_mb20.i_mb20Asserts.failCount;  // Bus protocol violations
    $display("Checks done: %0d mismatches, %0d other errors", mismatches, otherErrors);
    if (mismatches + otherErrors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: dv/mb20_asserts.sv
/* Concurrent protocol checks on the MB20 bus side. Bound into the top level
   so the testbench only has to compile this file */
`timescale 1ns/1ps

module mb20Asserts
  import memPkg::*;
(
  input bit clk,
  input bit reset,
  input bit start,
  input bit ackn,
  input bit busy,
  input bit validIn,
  input W36 dIn,
  input bit parIn
);

  int acknTotal;      // Words acknowledged since reset
  int validTotal;     // Words presented on the bus since reset
  int failCount = 0;  // Failed assertions so far

  always_ff @(posedge clk) begin
    if (reset) begin
      acknTotal <= 0;
      validTotal <= 0;
    end else begin
      if (ackn) acknTotal <= acknTotal + 1;
      if (validIn) validTotal <= validTotal + 1;
    end
  end

  // Strobes stay quiet while reset is applied
  resetQuiet: assert property (@(posedge clk) reset |-> !validIn && !ackn)
    else begin
      $error("ackn or validIn high during reset");
      failCount++;
    end

  // The acknowledge that opens a cycle follows a start
  acknInCycle: assert property (@(posedge clk) disable iff (reset)
    ackn && !$past(busy) |-> $past(start))
    else begin
      $error("ackn opened a cycle with no start before it");
      failCount++;
    end

  // The bus never sees more words than were acknowledged
  noExtraWords: assert property (@(posedge clk) disable iff (reset)
    validTotal <= acknTotal)
    else begin
      $error("more validIn pulses than ackn pulses");
      failCount++;
    end

  // Data and parity together hold an odd number of ones
  parityOdd: assert property (@(posedge clk) disable iff (reset)
    validIn |-> ^{dIn, parIn} == 1'b1)
    else begin
      $error("parIn does not give odd parity over dIn");
      failCount++;
    end

  // Data lines idle at zero between words
  idleZero: assert property (@(posedge clk) disable iff (reset)
    !validIn |-> dIn == '0)
    else begin
      $error("dIn not zero while validIn is low");
      failCount++;
    end

endmodule

bind mb20 mb20Asserts i_mb20Asserts (
  .clk    (clk),
  .reset  (reset),
  .start  (start),
  .ackn   (ackn),
  .busy   (busy),
  .validIn(validIn),
  .dIn    (dIn),
  .parIn  (parIn)
);

// File: hw/mb20.sv
/* Top level of the MB20 core memory model. Connects the phase sequencer, the
   word FIFO and the bus driver to the memory bus and write ports */
`timescale 1ns/1ps

module mb20
  import memPkg::*, mbusPkg::*;
(
  input  bit        clk,
  input  bit        reset,
  input  bit        start,      // Cycle start pulse
  input  tMbusStart startInfo,  // Address and request mask
  output bit        ackn,       // One pulse per word taken
  input  bit        busHold,    // Bus back-pressure
  output W36        dIn,
  output bit        parIn,
  output bit        validIn,
  input  bit        writeEn,    // Preload and update port
  input  tMemAddr   writeAddr,
  input  W36        writeData,
  output bit        busy
);

  bit fifoFull;
  bit fifoEmpty;
  bit push;
  bit pop;
  tMbusWord pushWord;  // Sequencer to FIFO
  tMbusWord popWord;   // FIFO head to driver

  mb20Phase i_mb20Phase (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .startInfo(startInfo),
    .writeEn  (writeEn),
    .writeAddr(writeAddr),
    .writeData(writeData),
    .full     (fifoFull),
    .push     (push),
    .pushWord (pushWord),
    .ackn     (ackn),
    .busy     (busy)
  );

  wordFifo i_wordFifo (
    .clk     (clk),
    .reset   (reset),
    .push    (push),
    .pushWord(pushWord),
    .pop     (pop),
    .popWord (popWord),
    .full    (fifoFull),
    .empty   (fifoEmpty)
  );

  mbusDriver i_mbusDriver (
    .clk    (clk),
    .reset  (reset),
    .empty  (fifoEmpty),
    .busHold(busHold),
    .popWord(popWord),
    .pop    (pop),
    .dIn    (dIn),
    .parIn  (parIn),
    .validIn(validIn)
  );

endmodule

// File: hw/mbusDriver.sv
/* Bus driver of the MB20 model. Pops read words from the FIFO and presents each
   on the bus data lines for one cycle with validIn and odd parity */
`timescale 1ns/1ps

module mbusDriver
  import memPkg::*, mbusPkg::*;
(
  input  bit       clk,
  input  bit       reset,
  input  bit       empty,    // FIFO holds nothing
  input  bit       busHold,  // Bus back-pressure level
  input  tMbusWord popWord,  // FIFO head
  output bit       pop,
  output W36       dIn,      // Bus data lines
  output bit       parIn,    // Odd parity of dIn
  output bit       validIn   // Strobe marking a word on dIn
);

  // Take the head whenever the bus will accept a new word
  assign pop = !empty && !busHold;

  // Output register one cycle behind the pop
  always_ff @(posedge clk) begin
    if (reset) begin
      validIn <= 1'b0;
      dIn <= '0;
    end else begin
      validIn <= pop;
      dIn <= pop ? popWord.data : '0;  // Lines idle at zero between words
    end
  end

  // Odd parity over whatever is on the lines (idle zero gives 1)
  assign parIn = ~^dIn;

endmodule

// File: hw/wordFifo.sv
/* Word FIFO between the MB20 sequencer and the bus driver. A circular buffer
   with a count that takes a push and a pop in the same cycle */
`timescale 1ns/1ps
`include "mb20_defs.svh"

module wordFifo
  import mbusPkg::*;
(
  input  bit       clk,
  input  bit       reset,
  input  bit       push,
  input  tMbusWord pushWord,
  input  bit       pop,
  output tMbusWord popWord,
  output bit       full,
  output bit       empty
);

  localparam int Depth = `MB20_FIFODEPTH;
  localparam int PtrBits = $clog2(Depth);
  localparam int CntBits = $clog2(Depth + 1);

  tMbusWord slots [Depth];    // Entry storage
  logic [PtrBits-1:0] wrPtr;  // Next slot to fill
  logic [PtrBits-1:0] rdPtr;  // Head of the queue
  logic [CntBits-1:0] count;  // Entries held
  bit doPush;
  bit doPop;

  assign full = (count == CntBits'(Depth));
  assign empty = (count == '0);

  // Ignore requests the buffer cannot honour
  assign doPush = push && !full;
  assign doPop = pop && !empty;

  // Head comes straight out of the storage flops
  // No combinational path from pushWord to popWord
  assign popWord = slots[rdPtr];

  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= (wrPtr == PtrBits'(Depth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= (rdPtr == PtrBits'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  // Storage write
  always_ff @(posedge clk) begin
    if (doPush) begin
      slots[wrPtr] <= pushWord;
    end
  end

endmodule

// File: hw/mb20Phase.sv
/* Phase sequencer of the MB20 model. Owns the core array, accepts start cycles,
   walks the request mask and pushes each read word into the word FIFO */
`timescale 1ns/1ps
`include "mb20_defs.svh"

module mb20Phase
  import memPkg::*, mbusPkg::*;
(
  input  bit        clk,
  input  bit        reset,
  input  bit        start,      // One-cycle start pulse
  input  tMbusStart startInfo,  // Sampled with start
  input  bit        writeEn,
  input  tMemAddr   writeAddr,
  input  W36        writeData,
  input  bit        full,       // FIFO has no free entry
  output bit        push,
  output tMbusWord  pushWord,
  output bit        ackn,
  output bit        busy
);

  localparam int IdxBits = $clog2(`MB20_MEMWORDS);

  W36 coreMem [`MB20_MEMWORDS];  // The core array

  logic [AddrLo:OffLo-1] qBase;  // Quadword base of the running cycle
  logic [OffLo:35] curOff;       // Word offset lined up with mask bit 0
  tReqMask remMask;              // Words not yet acknowledged
  logic [OffBits-1:0] skip;      // Cleared mask bits before the next word
  logic [OffLo:35] wordOff;      // Offset of the word going out now
  bit accept;                    // Start taken this cycle
  tMemAddr rdAddr;

  // A start while a cycle runs is dropped
  assign accept = start && !busy;

  // Busy as long as any requested word is left
  assign busy = |remMask;

  // Find the lowest set bit of the remaining mask
  always_comb begin : nextWord
    skip = '0;
    for (int k = `MB20_QUADWORDS - 1; k >= 0; k--) begin
      if (remMask[k]) skip = OffBits'(k);
    end
    wordOff = curOff + skip;  // Wraps inside the quadword
    rdAddr.quad.base = qBase;
    rdAddr.quad.offset = wordOff;
  end

  // Push holds off while the FIFO is full so no word is dropped
  assign push = busy && !full;
  assign ackn = push;  // Each pushed word is acknowledged in the same cycle

  // Asynchronous array read
  // A write at the same edge lands after the FIFO has taken the old word
  assign pushWord.data = coreMem[IdxBits'(rdAddr.linear)];
  assign pushWord.addr = rdAddr;

  // Mask bookkeeping
  always_ff @(posedge clk) begin
    if (reset) begin
      remMask <= '0;
    end else if (accept) begin
      remMask <= startInfo.reqMask;        // Zero mask leaves us idle
    end else if (push) begin
      remMask <= remMask << (skip + 1);    // Drop the sent bit and the skipped ones
    end
  end

  // Cycle address registers
  always_ff @(posedge clk) begin
    if (accept) begin
      qBase <= startInfo.addr.quad.base;
      curOff <= startInfo.addr.quad.offset;
    end else if (push) begin
      curOff <= wordOff + 1'b1;  // Next candidate follows the word just sent
    end
  end

  // Write port into the core array, any cycle
  always_ff @(posedge clk) begin
    if (writeEn) begin
      coreMem[IdxBits'(writeAddr.linear)] <= writeData;
    end
  end

endmodule

// File: hw/mbusPkg.sv
/* Bus-side structs of the MB20 model that pass from the start port through the
   sequencer, the word FIFO and the bus driver */
`include "mb20_defs.svh"

package mbusPkg;

  import memPkg::*;

  // Bit k asks for the word at (start offset + k) mod quadword size
  typedef logic [0:`MB20_QUADWORDS-1] tReqMask;

  // Start cycle request as sampled on the start pulse
  typedef struct packed {
    tMemAddr addr;     // First word address of the cycle
    tReqMask reqMask;  // Words to return
  } tMbusStart;

  // One read word on its way to the bus (the FIFO entry)
  typedef struct packed {
    W36 data;       // Word read from the core array
    tMemAddr addr;  // Where it came from
  } tMbusWord;

endpackage

// File: hw/memPkg.sv
/* Memory-side types of the MB20 model: the 36-bit word and the word address
   with its linear and quadword views. Imported by every block that touches memory */
`include "mb20_defs.svh"

package memPkg;

  // PDP-10 bit numbering where bit 0 is the MSB
  typedef logic [0:35] W36;

  localparam int AddrLo = 36 - `MB20_ADDRBITS;       // First bus address bit (14)
  localparam int OffBits = $clog2(`MB20_QUADWORDS);  // Bits of word offset
  localparam int OffLo = 36 - OffBits;               // First offset bit (34)

  // Quadword view of an address
  typedef struct packed {
    logic [AddrLo:OffLo-1] base;  // Quadword base
    logic [OffLo:35] offset;      // Word within the quadword
  } tQuadAddr;

  // One address word read two ways
  // The write port and the array index use it as a linear address
  // The sequencer steps the offset inside the quadword view
  typedef union packed {
    logic [AddrLo:35] linear;
    tQuadAddr quad;
  } tMemAddr;

endpackage

// File: hw/mb20_defs.svh
/* Sizing macros for the MB20 core memory model. Include this header wherever
   the core array, the address, a quadword or the word FIFO is sized */
`ifndef MB20_DEFS_SVH
`define MB20_DEFS_SVH

// Core array depth in words (small for simulation)
`define MB20_MEMWORDS 1024

// Word address width matching bus address bits 14..35
`define MB20_ADDRBITS 22

// Words moved by one quadword read cycle
`define MB20_QUADWORDS 4

// Word FIFO entries between the sequencer and the bus driver
`define MB20_FIFODEPTH 4

`endif
